//--- vlog.f
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_fetch.sv
verilog/rv_core.sv
sim/rv_core_properties.sv
sim/rv_core_tb.sv

//--- sim/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  logic      halt;

  word_t mem [1024];    // Shared instruction and data memory
  word_t snap [1024];
  word_t prog [$];
  word_t exp_q [$];     // Expected words for result slots at 0x400
  int    checks = 0;
  int    errors = 0;
  word_t lcg_state = 32'd15;

  always #4 clk = ~clk;

  rv_core rv_core_i (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  assign imem_data  = mem[imem_addr[11:2]];
  assign dmem_rdata = mem[dmem_req.addr[11:2]];

  always @(posedge clk) begin
    if (!rst) begin
      if (dmem_req.be[0]) mem[dmem_req.addr[11:2]][7:0]   <= dmem_req.wdata[7:0];
      if (dmem_req.be[1]) mem[dmem_req.addr[11:2]][15:8]  <= dmem_req.wdata[15:8];
      if (dmem_req.be[2]) mem[dmem_req.addr[11:2]][23:16] <= dmem_req.wdata[23:16];
      if (dmem_req.be[3]) mem[dmem_req.addr[11:2]][31:24] <= dmem_req.wdata[31:24];
    end
  end

  function automatic word_t rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t fill_word(input int idx);
    return (idx * 32'h9E37_79B9) ^ 32'h0F1E_2D3C;
  endfunction

  // Instruction encoders
  function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                  input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // Reference model of the RV32I integer ops
  function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    logic [4:0] s;
    s = b[4:0];
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << s;
      3'd2:    return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return (alt && a[31]) ? ~(~a >> s) : a >> s;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_taken(input logic [2:0] f3, input word_t a, input word_t b);
    logic lt_s;
    logic lt_u;
    lt_u = a < b;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return lt_s;
      3'd5:    return !lt_s;
      3'd6:    return lt_u;
      default: return !lt_u;
    endcase
  endfunction

  function automatic word_t here();
    return word_t'(prog.size() * 4);
  endfunction

  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  task automatic addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    emit(enc_i(imm, rs1, 3'b000, rd, OP_IMM));
  endtask

  task automatic load_const(input logic [4:0] rd, input word_t value);
    word_t upper;
    upper = value + 32'h800;   // Round for the signed low part
    emit(enc_u(upper[31:12], rd, OP_LUI));
    addi(rd, rd, value[11:0]);
  endtask

  task automatic store_reg(input logic [4:0] rs, input word_t expected);
    emit(enc_s(12'(exp_q.size() * 4), rs, 5'd31, 3'b010));
    exp_q.push_back(expected);
  endtask

  task automatic check(input word_t expected, input word_t actual, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, what, expected, actual);
    end
  endtask

  task automatic start_test;
    prog.delete();
    exp_q.delete();
    for (int i = 0; i < 1024; i++) begin
      mem[i] <= fill_word(i);
    end
    addi(5'd31, 5'd0, 12'h400);   // x31 is the data base
  endtask

  task automatic run_program;
    int cycles;
    rst = 1'b1;
    emit(enc_i(12'h000, 5'd0, 3'b000, 5'd0, OP_SYSTEM));   // ECALL
    for (int i = 0; i < prog.size(); i++) begin
      mem[i] <= prog[i];
    end
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    cycles = 0;
    while (!halt && cycles < 2000) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!halt) begin
      errors++;
      $display("Timeout at %0t: core did not halt within 2000 cycles", $time);
    end
  endtask

  task automatic check_slots(input string name);
    for (int i = 0; i < exp_q.size(); i++) begin
      check(exp_q[i], mem[256 + i], $sformatf("%s slot %0d", name, i));
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    $display("Test %s finished, %0d errors", name, errors - err0);
  endtask

  task automatic test_alu;
    word_t       a;
    word_t       b;
    word_t       r;
    word_t       pc_v;
    logic [11:0] imm12;
    logic [19:0] up;
    int          err0;
    err0 = errors;
    start_test();
    a = rand_word();
    b = rand_word();
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 8; k++) begin
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'(k), 5'd3));
      store_reg(5'd3, ref_alu(3'(k), 1'b0, a, b));
    end
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));   // SUB
    store_reg(5'd3, ref_alu(3'b000, 1'b1, a, b));
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3));   // SRA
    store_reg(5'd3, ref_alu(3'b101, 1'b1, a, b));
    for (int k = 0; k < 9; k++) begin
      r = rand_word();
      imm12 = r[11:0];
      if (k == 1 || k == 5) imm12 = {7'h00, r[4:0]};
      if (k == 8) imm12 = {7'h20, r[4:0]};         // SRAI
      emit(enc_i(imm12, 5'd1, (k == 8) ? 3'b101 : 3'(k), 5'd3, OP_IMM));
      store_reg(5'd3, ref_alu((k == 8) ? 3'b101 : 3'(k), k == 8, a,
                              {{20{imm12[11]}}, imm12}));
    end
    r = rand_word();
    up = r[31:12];
    emit(enc_u(up, 5'd3, OP_LUI));
    store_reg(5'd3, {up, 12'h000});
    pc_v = here();
    emit(enc_u(up, 5'd3, OP_AUIPC));
    store_reg(5'd3, pc_v + {up, 12'h000});
    run_program();
    check_slots("alu");
    finish_test("alu", err0);
  endtask

  task automatic test_branches;
    word_t      pa [3];
    word_t      pb [3];
    logic [2:0] conds [6];
    word_t      pc_v;
    int         err0;
    err0 = errors;
    pa = '{32'd5, 32'hFFFF_FFFD, 32'd2};   // Equal, signed less, unsigned less
    pb = '{32'd5, 32'd2, 32'hFFFF_FFFD};
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    start_test();
    for (int p = 0; p < 3; p++) begin
      load_const(5'd1, pa[p]);
      load_const(5'd2, pb[p]);
      for (int c = 0; c < 6; c++) begin
        addi(5'd3, 5'd0, 12'd0);
        emit(enc_b(13'd8, 5'd2, 5'd1, conds[c]));
        addi(5'd3, 5'd0, 12'd1);   // Marker skipped when taken
        store_reg(5'd3, ref_taken(conds[c], pa[p], pb[p]) ? 32'd0 : 32'd1);
      end
    end
    addi(5'd7, 5'd0, 12'd0);
    pc_v = here();
    emit(enc_j(21'd8, 5'd5));
    addi(5'd7, 5'd0, 12'd1);
    store_reg(5'd5, pc_v + 32'd4);
    store_reg(5'd7, 32'd0);
    pc_v = here();
    emit(enc_u(20'h00000, 5'd8, OP_AUIPC));
    emit(enc_i(12'd13, 5'd8, 3'b000, 5'd9, OP_JALR));   // Odd target with bit 0 dropped
    addi(5'd7, 5'd0, 12'd1);
    store_reg(5'd9, pc_v + 32'd8);
    store_reg(5'd7, 32'd0);
    run_program();
    check_slots("branch");
    finish_test("branch", err0);
  endtask

  task automatic test_loads;
    word_t data;
    int    err0;
    err0 = errors;
    start_test();
    data = rand_word();
    mem[384] <= data;   // Address 0x600
    for (int off = 0; off < 4; off++) begin
      emit(enc_i(12'(32'h200 + off), 5'd31, 3'b000, 5'd10, OP_LOAD));
      store_reg(5'd10, {{24{data[8*off+7]}}, data[8*off +: 8]});
      emit(enc_i(12'(32'h200 + off), 5'd31, 3'b100, 5'd10, OP_LOAD));
      store_reg(5'd10, {24'h000000, data[8*off +: 8]});
    end
    for (int off = 0; off < 4; off += 2) begin
      emit(enc_i(12'(32'h200 + off), 5'd31, 3'b001, 5'd10, OP_LOAD));
      store_reg(5'd10, {{16{data[8*off+15]}}, data[8*off +: 16]});
      emit(enc_i(12'(32'h200 + off), 5'd31, 3'b101, 5'd10, OP_LOAD));
      store_reg(5'd10, {16'h0000, data[8*off +: 16]});
    end
    emit(enc_i(12'h200, 5'd31, 3'b010, 5'd10, OP_LOAD));
    store_reg(5'd10, data);
    run_program();
    check_slots("load");
    finish_test("load", err0);
  endtask

  task automatic test_stores;
    word_t v;
    word_t w;
    int    err0;
    err0 = errors;
    start_test();
    v = rand_word();
    load_const(5'd11, v);
    // SB into words 385..388 and SH into words 389..390
    for (int off = 0; off < 4; off++) begin
      emit(enc_s(12'(32'h204 + 4 * off + off), 5'd11, 5'd31, 3'b000));
    end
    for (int h = 0; h < 2; h++) begin
      emit(enc_s(12'(32'h214 + 6 * h), 5'd11, 5'd31, 3'b001));
    end
    run_program();
    for (int off = 0; off < 4; off++) begin
      w = fill_word(385 + off);
      w[8*off +: 8] = v[7:0];
      check(w, mem[385 + off], $sformatf("SB offset %0d", off));
    end
    for (int h = 0; h < 2; h++) begin
      w = fill_word(389 + h);
      w[16*h +: 16] = v[15:0];
      check(w, mem[389 + h], $sformatf("SH offset %0d", 2 * h));
    end
    finish_test("store", err0);
  endtask

  task automatic test_x0_misaligned;
    int err0;
    err0 = errors;
    start_test();
    addi(5'd0, 5'd0, 12'd123);
    store_reg(5'd0, 32'd0);
    load_const(5'd12, rand_word());
    emit(enc_s(12'h221, 5'd12, 5'd31, 3'b010));   // SW to byte 1 of word 392
    emit(enc_s(12'h225, 5'd12, 5'd31, 3'b001));   // SH to byte 1 of word 393
    load_const(5'd13, 32'h1234_5678);
    emit(enc_i(12'h229, 5'd31, 3'b010, 5'd13, OP_LOAD));
    emit(enc_i(12'h22B, 5'd31, 3'b001, 5'd13, OP_LOAD));
    store_reg(5'd13, 32'h1234_5678);
    run_program();
    check_slots("x0_misaligned");
    check(fill_word(392), mem[392], "misaligned SW target");
    check(fill_word(393), mem[393], "misaligned SH target");
    finish_test("x0_misaligned", err0);
  endtask

  task automatic test_halt;
    word_t halt_pc;
    int    changed;
    int    err0;
    err0 = errors;
    start_test();
    addi(5'd1, 5'd0, 12'd77);
    halt_pc = here();
    emit(enc_i(12'h000, 5'd0, 3'b000, 5'd0, OP_SYSTEM));
    emit(enc_s(12'h000, 5'd1, 5'd31, 3'b010));   // Never reached
    run_program();
    check(halt_pc, imem_addr, "PC at halt");
    snap = mem;
    for (int c = 0; c < 20; c++) begin
      @(posedge clk);
      #1;
      check(32'd1, {31'd0, halt}, "halt level");
      check(halt_pc, imem_addr, "PC while halted");
      check(32'd0, {28'd0, dmem_req.be}, "byte enables while halted");
    end
    changed = 0;
    for (int i = 0; i < 1024; i++) begin
      if (mem[i] !== snap[i]) changed++;
    end
    check(32'd0, changed, "memory words changed while halted");
    finish_test("halt", err0);
  endtask

  initial begin
    test_alu();
    test_branches();
    test_loads();
    test_stores();
    test_x0_misaligned();
    test_halt();
    errors += rv_core_i.props_i.assert_errors;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sim/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties (
  input logic              clk,
  input logic              rst,
  input rv_pkg::word_t     imem_addr,
  input rv_pkg::dmem_req_t dmem_req,
  input logic              halt
);
  int assert_errors = 0;

  pc_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else begin
      assert_errors++;
      $error("imem_addr is not word aligned");
    end

  // Halted core issues no stores
  halt_no_store: assert property (@(posedge clk) disable iff (rst)
      halt |-> dmem_req.be == 4'b0000)
    else begin
      assert_errors++;
      $error("byte enables active while halted");
    end

  halt_pc_hold: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(imem_addr))
    else begin
      assert_errors++;
      $error("imem_addr moved while halted");
    end

  reset_clears_halt: assert property (@(posedge clk) rst |=> !halt)
    else begin
      assert_errors++;
      $error("halt high in the cycle after reset");
    end

endmodule

bind rv_core rv_core_properties props_i (
  .clk       (clk),
  .rst       (rst),
  .imem_addr (imem_addr),
  .dmem_req  (dmem_req),
  .halt      (halt)
);

//--- verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic              clk,
  input  logic              rst,
  output rv_pkg::word_t     imem_addr,
  input  rv_pkg::word_t     imem_data,
  output rv_pkg::dmem_req_t dmem_req,
  input  rv_pkg::word_t     dmem_rdata,
  output logic              halt
);
  import rv_pkg::*;

  ctrl_t                 ctrl;
  word_t                 imm;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  word_t                 rs1_data;
  word_t                 rs2_data;
  word_t                 alu_a;
  word_t                 alu_b;
  word_t                 alu_result;
  logic                  br_true;
  word_t                 load_data;
  logic                  mem_ok;
  logic                  rf_we;
  word_t                 rf_wdata;

  rv_fetch fetch_i (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .imm        (imm),
    .alu_result (alu_result),
    .br_true    (br_true),
    .pc         (imem_addr),
    .halt       (halt)
  );

  rv_decoder decoder_i (
    .insn (imem_data),
    .ctrl (ctrl),
    .imm  (imm),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_we),
    .rd       (rd),
    .rd_data  (rf_wdata),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = ctrl.a_is_pc  ? imem_addr : rs1_data;   // AUIPC
  assign alu_b = ctrl.b_is_imm ? imm       : rs2_data;

  rv_alu alu_i (
    .op      (ctrl.alu_op),
    .a       (alu_a),
    .b       (alu_b),
    .cond    (ctrl.br_cond),
    .result  (alu_result),
    .br_true (br_true)
  );

  rv_lsu lsu_i (
    .ctrl       (ctrl),
    .addr       (alu_result),   // Effective address is the ALU sum
    .store_data (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (dmem_req),
    .load_data  (load_data),
    .mem_ok     (mem_ok)
  );

  always_comb begin
    case (ctrl.wb_sel)
      LOAD:     rf_wdata = load_data;
      PC_PLUS4: rf_wdata = imem_addr + 32'd4;   // Link value
      default:  rf_wdata = alu_result;
    endcase
  end

  // Misaligned loads leave rd untouched
  assign rf_we = ctrl.rf_we && !halt && (!ctrl.is_load || mem_ok);

endmodule

//--- verilog/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t alu_result,
  input  logic          br_true,
  output rv_pkg::word_t pc,
  output logic          halt
);
  import rv_pkg::*;

  word_t next_pc;

  always_comb begin
    if (ctrl.is_jal || (ctrl.is_branch && br_true)) begin
      next_pc = pc + imm;
    end else if (ctrl.is_jalr) begin
      next_pc = {alu_result[XLEN-1:1], 1'b0};
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  // ECALL parks the PC on itself until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= '0;
      halt <= 1'b0;
    end else if (!halt) begin
      if (ctrl.is_ecall) begin
        halt <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

//--- verilog/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
  input  rv_pkg::ctrl_t     ctrl,
  input  rv_pkg::word_t     addr,
  input  rv_pkg::word_t     store_data,
  input  rv_pkg::word_t     dmem_rdata,
  output rv_pkg::dmem_req_t dmem_req,
  output rv_pkg::word_t     load_data,
  output logic              mem_ok
);
  import rv_pkg::*;

  logic [1:0] offset;
  word_t      lane_data;

  assign offset = addr[1:0];

  always_comb begin
    case (ctrl.mem_size)
      BYTE:    mem_ok = 1'b1;
      HALF:    mem_ok = !offset[0];
      WORD:    mem_ok = (offset == 2'b00);
      default: mem_ok = 1'b0;
    endcase
  end

  always_comb begin
    dmem_req.addr = {addr[XLEN-1:2], 2'b00};
    dmem_req.be   = 4'b0000;
    case (ctrl.mem_size)
      BYTE:    dmem_req.wdata = {4{store_data[7:0]}};   // Same byte in every lane
      HALF:    dmem_req.wdata = {2{store_data[15:0]}};
      default: dmem_req.wdata = store_data;
    endcase
    if (ctrl.is_store && mem_ok) begin
      case (ctrl.mem_size)
        BYTE:    dmem_req.be = 4'b0001 << offset;
        HALF:    dmem_req.be = offset[1] ? 4'b1100 : 4'b0011;
        default: dmem_req.be = 4'b1111;
      endcase
    end
  end

  // Move the addressed byte or half down to bit 0
  assign lane_data = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (ctrl.mem_size)
      BYTE: begin
        load_data = ctrl.mem_unsigned ? {24'b0, lane_data[7:0]}
                                      : {{24{lane_data[7]}}, lane_data[7:0]};
      end
      HALF: begin
        load_data = ctrl.mem_unsigned ? {16'b0, lane_data[15:0]}
                                      : {{16{lane_data[15]}}, lane_data[15:0]};
      end
      default: load_data = dmem_rdata;
    endcase
  end

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_e  op,
  input  rv_pkg::word_t    a,
  input  rv_pkg::word_t    b,
  input  rv_pkg::br_cond_e cond,
  output rv_pkg::word_t    result,
  output logic             br_true
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign eq    = (a == b);
  assign lt_s  = ($signed(a) < $signed(b));
  assign lt_u  = (a < b);

  always_comb begin
    case (op)
      ADD:     result = a + b;
      SUB:     result = a - b;
      SLL:     result = a << shamt;
      SLT:     result = {{(XLEN-1){1'b0}}, lt_s};
      SLTU:    result = {{(XLEN-1){1'b0}}, lt_u};
      XOR:     result = a ^ b;
      SRL:     result = a >> shamt;
      SRA:     result = word_t'($signed(a) >>> shamt);
      OR:      result = a | b;
      AND:     result = a & b;
      PASS_B:  result = b;   // LUI
      default: result = '0;
    endcase
  end

  // Branch compare runs alongside, whatever op says
  always_comb begin
    case (cond)
      EQ:      br_true = eq;
      NE:      br_true = !eq;
      LT:      br_true = lt_s;
      GE:      br_true = !lt_s;
      LTU:     br_true = lt_u;
      GEU:     br_true = !lt_u;
      default: br_true = 1'b0;
    endcase
  end

endmodule

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
  input  rv_pkg::word_t                 rd_data,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
  output rv_pkg::word_t                 rs1_data,
  output rv_pkg::word_t                 rs2_data
);
  import rv_pkg::*;

  word_t regs [1:NUM_REGS-1];   // No storage for x0

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- verilog/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::rv_insn_u                 insn,
  output rv_pkg::ctrl_t                    ctrl,
  output rv_pkg::word_t                    imm,
  output logic [rv_pkg::REG_ADDR_W-1:0]    rs1,
  output logic [rv_pkg::REG_ADDR_W-1:0]    rs2,
  output logic [rv_pkg::REG_ADDR_W-1:0]    rd
);
  import rv_pkg::*;

  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;
  logic    is_reg;
  logic    f7_zero;
  logic    f7_alt;
  alu_op_e arith_op;
  logic    arith_ok;

  assign rs1 = insn.r.rs1;
  assign rs2 = insn.r.rs2;
  assign rd  = insn.r.rd;

  // Sign-extended immediates for each format
  assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
  assign imm_s = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
  assign imm_b = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm, 12'b0};
  assign imm_j = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                  insn.j.imm_11, insn.j.imm_10_1, 1'b0};

  assign is_reg  = (insn.r.opcode == OP_REG);
  assign f7_zero = (insn.r.funct7 == 7'b0000000);
  assign f7_alt  = (insn.r.funct7 == 7'b0100000);

  // ALU op shared by OP and OP-IMM; funct7 only matters for shifts and R-type
  always_comb begin
    arith_op = ADD;
    arith_ok = !is_reg || f7_zero;
    case (insn.r.funct3)
      3'b000: begin
        arith_op = (is_reg && f7_alt) ? SUB : ADD;
        arith_ok = !is_reg || f7_zero || f7_alt;
      end
      3'b001: begin
        arith_op = SLL;
        arith_ok = f7_zero;
      end
      3'b010: arith_op = SLT;
      3'b011: arith_op = SLTU;
      3'b100: arith_op = XOR;
      3'b101: begin
        arith_op = f7_alt ? SRA : SRL;
        arith_ok = f7_zero || f7_alt;
      end
      3'b110: arith_op = OR;
      default: arith_op = AND;
    endcase
  end

  always_comb begin
    ctrl = '0;   // Anything unrecognized stays a no-op
    imm  = '0;
    case (insn.r.opcode)
      OP_LUI: begin
        ctrl.alu_op   = PASS_B;
        ctrl.b_is_imm = 1'b1;
        ctrl.rf_we    = 1'b1;
        imm           = imm_u;
      end
      OP_AUIPC: begin
        ctrl.a_is_pc  = 1'b1;
        ctrl.b_is_imm = 1'b1;
        ctrl.rf_we    = 1'b1;
        imm           = imm_u;
      end
      OP_JAL: begin
        ctrl.is_jal = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.wb_sel = PC_PLUS4;
        imm         = imm_j;
      end
      OP_JALR: begin
        if (insn.i.funct3 == 3'b000) begin
          ctrl.is_jalr  = 1'b1;
          ctrl.b_is_imm = 1'b1;   // Target comes from the ALU sum
          ctrl.rf_we    = 1'b1;
          ctrl.wb_sel   = PC_PLUS4;
        end
        imm = imm_i;
      end
      OP_BRANCH: begin
        if (insn.b.funct3[2:1] != 2'b01) begin
          ctrl.is_branch = 1'b1;
          ctrl.br_cond   = br_cond_e'(insn.b.funct3);
        end
        imm = imm_b;
      end
      OP_LOAD: begin
        if (insn.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          ctrl.is_load      = 1'b1;
          ctrl.b_is_imm     = 1'b1;
          ctrl.rf_we        = 1'b1;
          ctrl.wb_sel       = LOAD;
          ctrl.mem_size     = mem_size_e'(insn.i.funct3[1:0]);
          ctrl.mem_unsigned = insn.i.funct3[2];
        end
        imm = imm_i;
      end
      OP_STORE: begin
        if (insn.s.funct3 inside {3'b000, 3'b001, 3'b010}) begin
          ctrl.is_store = 1'b1;
          ctrl.b_is_imm = 1'b1;
          ctrl.mem_size = mem_size_e'(insn.s.funct3[1:0]);
        end
        imm = imm_s;
      end
      OP_IMM: begin
        if (arith_ok) begin
          ctrl.alu_op   = arith_op;
          ctrl.b_is_imm = 1'b1;
          ctrl.rf_we    = 1'b1;
        end
        imm = imm_i;
      end
      OP_REG: begin
        if (arith_ok) begin
          ctrl.alu_op = arith_op;
          ctrl.rf_we  = 1'b1;
        end
      end
      OP_SYSTEM: begin
        // Only ECALL; other system ops fall through as no-ops
        ctrl.is_ecall = ({insn.i.imm, insn.i.rs1, insn.i.funct3, insn.i.rd} == '0);
      end
      OP_MISC_MEM: begin
        // FENCE has nothing to order here
      end
      default: begin
      end
    endcase
  end

endmodule

//--- verilog/rv_pkg.sv
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // Major opcodes, RV32I base
  localparam logic [6:0] OP_LOAD     = 7'b0000011;
  localparam logic [6:0] OP_STORE    = 7'b0100011;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_IMM      = 7'b0010011;
  localparam logic [6:0] OP_REG      = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM   = 7'b1110011;
  localparam logic [6:0] OP_AUIPC    = 7'b0010111;
  localparam logic [6:0] OP_LUI      = 7'b0110111;

  typedef logic [XLEN-1:0] word_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // Branch offset bits are scattered, bit 0 implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_insn_u;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
  } alu_op_e;

  // Encoded as the branch funct3
  typedef enum logic [2:0] {
    EQ  = 3'b000,
    NE  = 3'b001,
    LT  = 3'b100,
    GE  = 3'b101,
    LTU = 3'b110,
    GEU = 3'b111
  } br_cond_e;

  typedef enum logic [1:0] {BYTE = 2'b00, HALF = 2'b01, WORD = 2'b10} mem_size_e;

  typedef enum logic [1:0] {ALU = 2'b00, LOAD = 2'b01, PC_PLUS4 = 2'b10} wb_sel_e;

  typedef struct packed {
    alu_op_e   alu_op;
    logic      a_is_pc;
    logic      b_is_imm;
    logic      rf_we;
    wb_sel_e   wb_sel;
    logic      is_load;
    logic      is_store;
    mem_size_e mem_size;
    logic      mem_unsigned;
    logic      is_branch;
    br_cond_e  br_cond;
    logic      is_jal;
    logic      is_jalr;
    logic      is_ecall;
  } ctrl_t;

  typedef struct packed {
    word_t      addr;   // Word aligned
    word_t      wdata;
    logic [3:0] be;
  } dmem_req_t;

endpackage
